// ==== verilog/fb_pkg.sv ====
// ==============================
// framebuffer shared definitions
// pixel widths, colour expansion, default geometry
// ==============================

package fb_pkg;

    // stored pixel and output channel widths
    localparam int COLR_W = 4;
    localparam int RGB_W  = 8;

    // default screen and framebuffer geometry
    localparam int DEF_H_ACTIVE  = 32;
    localparam int DEF_V_ACTIVE  = 24;
    localparam int DEF_FB_WIDTH  = 16;
    localparam int DEF_FB_HEIGHT = 12;

    // nibble repeated to fill a channel, so 4'hA gives 8'hAA
    function automatic logic [RGB_W-1:0] expand_colr(input logic [COLR_W-1:0] colr);
        return {colr, colr};
    endfunction

endpackage

// ==== verilog/display_timing.sv ====
// ==============================
// display timing generator
// sweeps the screen, makes sync, de and frame
// ==============================
`timescale 1ns/100ps

module display_timing #(
    parameter int H_ACTIVE = 32,
    parameter int H_FP     = 2,
    parameter int H_SYNC   = 3,
    parameter int H_BP     = 3,
    parameter int V_ACTIVE = 24,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 1
) (
    input  logic        clk_pix,
    input  logic        arst_n,
    output logic [15:0] sx,
    output logic [15:0] sy,
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output logic        frame
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HS_STA  = H_ACTIVE + H_FP;
    localparam int HS_END  = HS_STA + H_SYNC;
    localparam int VS_STA  = V_ACTIVE + V_FP;
    localparam int VS_END  = VS_STA + V_SYNC;

    logic [15:0] sx_nxt;
    logic [15:0] sy_nxt;

    // next position, wrapping at the line and frame ends
    always_comb begin
        sx_nxt = sx + 1'b1;
        sy_nxt = sy;
        if (sx == H_TOTAL - 1) begin
            sx_nxt = '0;
            sy_nxt = (sy == V_TOTAL - 1) ? '0 : sy + 1'b1;
        end
    end

    // strobes decoded from the next position so they move with sx and sy
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= 16'(H_TOTAL - 1);  // first edge out of reset lands on 0,0
            sy    <= 16'(V_TOTAL - 1);
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            hsync <= (sx_nxt >= HS_STA) && (sx_nxt < HS_END);
            vsync <= (sy_nxt >= VS_STA) && (sy_nxt < VS_END);
            de    <= (sx_nxt < H_ACTIVE) && (sy_nxt < V_ACTIVE);
            frame <= (sx_nxt == 0) && (sy_nxt == 0);
        end
    end

    a_sx_range: assert property (
        @(posedge clk_pix) disable iff (!arst_n) sx < H_TOTAL
    ) else $error("sx ran past the line total");

endmodule

// ==== verilog/fb_ram.sv ====
// ==============================
// framebuffer RAM
// single port, one-cycle read latency
// ==============================
`timescale 1ns/100ps

module fb_ram #(
    parameter int DEPTH  = 192,
    parameter int ADDR_W = 8
) (
    input  logic                      clk_pix,
    input  logic                      en,
    input  logic                      we,
    input  logic [ADDR_W-1:0]         addr,
    input  logic [fb_pkg::COLR_W-1:0] din,
    output logic [fb_pkg::COLR_W-1:0] dout
);

    logic [fb_pkg::COLR_W-1:0] mem [DEPTH];

    // no image file, so the screen starts black
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];  // dout holds between reads
            end
        end
    end

endmodule

// ==== verilog/fb_arbiter.sv ====
// ==============================
// framebuffer port arbiter
// scanout read wins, drawer writes in the gaps
// ==============================
`timescale 1ns/100ps

module fb_arbiter #(
    parameter int ADDR_W = 8
) (
    input  logic                      clk_pix,
    input  logic                      arst_n,
    input  logic                      rd_req,
    input  logic [ADDR_W-1:0]         rd_addr,
    input  logic                      wr_req,
    input  logic [ADDR_W-1:0]         wr_addr,
    input  logic [fb_pkg::COLR_W-1:0] wr_colr,
    output logic                      wr_gnt,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [ADDR_W-1:0]         ram_addr,
    output logic [fb_pkg::COLR_W-1:0] ram_din
);

    // fixed priority, read first
    always_comb begin
        wr_gnt   = wr_req && !rd_req;
        ram_en   = rd_req || wr_req;
        ram_we   = wr_gnt;
        ram_addr = rd_req ? rd_addr : wr_addr;
        ram_din  = wr_colr;  // only sampled when we is high
    end

    // the scanout must never lose a read slot to the drawer
    a_no_wr_on_rd: assert property (
        @(posedge clk_pix) disable iff (!arst_n) wr_gnt |-> !rd_req
    ) else $error("write granted during a read request");

    a_gnt_needs_req: assert property (
        @(posedge clk_pix) disable iff (!arst_n) $rose(wr_gnt) |-> wr_req
    ) else $error("write grant rose without a request");

endmodule

// ==== verilog/box_drawer.sv ====
// ==============================
// box drawer
// writes a one-pixel border once per start strobe
// ==============================
`timescale 1ns/100ps

module box_drawer #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int ADDR_W    = 8
) (
    input  logic                      clk_pix,
    input  logic                      arst_n,
    input  logic                      draw_start,
    input  logic [fb_pkg::COLR_W-1:0] draw_colr,
    output logic                      wr_req,
    output logic [ADDR_W-1:0]         wr_addr,
    output logic [fb_pkg::COLR_W-1:0] wr_colr,
    input  logic                      wr_gnt,
    output logic                      draw_busy
);

    localparam int CNT_W = $clog2((FB_WIDTH > FB_HEIGHT) ? FB_WIDTH : FB_HEIGHT);

    localparam logic [ADDR_W-1:0] ROW_STEP  = ADDR_W'(FB_WIDTH);
    localparam logic [ADDR_W-1:0] BOT_START = ADDR_W'((FB_HEIGHT - 1) * FB_WIDTH + 1);

    localparam logic [2:0] IDLE   = 3'd0;
    localparam logic [2:0] TOP    = 3'd1;
    localparam logic [2:0] RIGHT  = 3'd2;
    localparam logic [2:0] LEFT   = 3'd3;
    localparam logic [2:0] BOTTOM = 3'd4;

    logic [2:0]       state;
    logic [CNT_W-1:0] cnt;

    assign draw_busy = (state != IDLE);
    assign wr_req    = draw_busy;  // every busy cycle carries a pixel

    // each corner is written once
    // top row is full, the sides skip row 0 and the bottom skips both end columns
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            cnt     <= '0;
            wr_addr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (draw_start) begin
                        wr_addr <= '0;
                        cnt     <= '0;
                        state   <= TOP;
                    end
                end
                TOP: begin
                    if (wr_gnt) begin
                        if (cnt < FB_WIDTH - 1) begin
                            wr_addr <= wr_addr + 1'b1;
                            cnt     <= cnt + 1'b1;
                        end else begin
                            wr_addr <= wr_addr + ROW_STEP;  // right column, row 1
                            cnt     <= '0;
                            state   <= RIGHT;
                        end
                    end
                end
                RIGHT: begin
                    if (wr_gnt) begin
                        if (cnt < FB_HEIGHT - 2) begin
                            wr_addr <= wr_addr + ROW_STEP;
                            cnt     <= cnt + 1'b1;
                        end else begin
                            wr_addr <= ROW_STEP;  // left column, row 1
                            cnt     <= '0;
                            state   <= LEFT;
                        end
                    end
                end
                LEFT: begin
                    if (wr_gnt) begin
                        if (cnt < FB_HEIGHT - 2) begin
                            wr_addr <= wr_addr + ROW_STEP;
                            cnt     <= cnt + 1'b1;
                        end else begin
                            wr_addr <= BOT_START;
                            cnt     <= '0;
                            state   <= BOTTOM;
                        end
                    end
                end
                BOTTOM: begin
                    if (wr_gnt) begin
                        if (cnt < FB_WIDTH - 3) begin
                            wr_addr <= wr_addr + 1'b1;
                            cnt     <= cnt + 1'b1;
                        end else begin
                            state <= IDLE;  // ready for a redraw
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // colour latched on an accepted start only
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && draw_start) begin
            wr_colr <= draw_colr;
        end
    end

    a_addr_range: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        wr_req |-> wr_addr < FB_WIDTH * FB_HEIGHT
    ) else $error("drawer address outside the framebuffer");

endmodule

// ==== verilog/fb_scanout.sv ====
// ==============================
// framebuffer scanout
// raster reads, pipeline alignment, pixel outputs
// ==============================
`timescale 1ns/100ps

module fb_scanout #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int ADDR_W    = 8
) (
    input  logic                      clk_pix,
    input  logic                      arst_n,
    input  logic [15:0]               sx,
    input  logic [15:0]               sy,
    input  logic                      hsync,
    input  logic                      vsync,
    input  logic                      de,
    input  logic                      frame,
    output logic                      rd_req,
    output logic [ADDR_W-1:0]         rd_addr,
    input  logic [fb_pkg::COLR_W-1:0] rd_data,
    output logic [fb_pkg::RGB_W-1:0]  pix_red,
    output logic [fb_pkg::RGB_W-1:0]  pix_green,
    output logic [fb_pkg::RGB_W-1:0]  pix_blue,
    output logic                      pix_hsync,
    output logic                      pix_vsync,
    output logic                      pix_de
);

    logic              paint;
    logic [ADDR_W-1:0] addr_q;
    logic              paint_p1;
    logic              hsync_p1;
    logic              vsync_p1;
    logic              de_p1;

    // painted area is the top-left corner of the active screen
    assign paint  = de && (sx < FB_WIDTH) && (sy < FB_HEIGHT);
    assign rd_req = paint;

    // pixel 0 is read on the frame strobe itself
    assign rd_addr = frame ? '0 : addr_q;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
        end else if (paint) begin
            addr_q <= rd_addr + 1'b1;
        end
    end

    // stage 1 waits for the RAM read and stage 2 registers the outputs
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            paint_p1  <= 1'b0;
            hsync_p1  <= 1'b0;
            vsync_p1  <= 1'b0;
            de_p1     <= 1'b0;
            pix_hsync <= 1'b0;
            pix_vsync <= 1'b0;
            pix_de    <= 1'b0;
            pix_red   <= '0;
            pix_green <= '0;
            pix_blue  <= '0;
        end else begin
            paint_p1  <= paint;
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
            de_p1     <= de;
            pix_hsync <= hsync_p1;
            pix_vsync <= vsync_p1;
            pix_de    <= de_p1;
            pix_red   <= paint_p1 ? fb_pkg::expand_colr(rd_data) : '0;  // grey scale
            pix_green <= paint_p1 ? fb_pkg::expand_colr(rd_data) : '0;
            pix_blue  <= paint_p1 ? fb_pkg::expand_colr(rd_data) : '0;
        end
    end

endmodule

// ==== verilog/fb_top.sv ====
// ==============================
// framebuffer display top level
// ==============================
`timescale 1ns/100ps

module fb_top #(
    parameter int H_ACTIVE  = fb_pkg::DEF_H_ACTIVE,
    parameter int H_FP      = 2,
    parameter int H_SYNC    = 3,
    parameter int H_BP      = 3,
    parameter int V_ACTIVE  = fb_pkg::DEF_V_ACTIVE,
    parameter int V_FP      = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 1,
    parameter int FB_WIDTH  = fb_pkg::DEF_FB_WIDTH,
    parameter int FB_HEIGHT = fb_pkg::DEF_FB_HEIGHT
) (
    input  logic                      clk_pix,
    input  logic                      arst_n,
    input  logic                      draw_start,
    input  logic [fb_pkg::COLR_W-1:0] draw_colr,
    output logic [fb_pkg::RGB_W-1:0]  pix_red,
    output logic [fb_pkg::RGB_W-1:0]  pix_green,
    output logic [fb_pkg::RGB_W-1:0]  pix_blue,
    output logic                      pix_hsync,
    output logic                      pix_vsync,
    output logic                      pix_de,
    output logic                      draw_busy
);

    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDR_W = $clog2(FB_DEPTH);

    logic [15:0]                sx;
    logic [15:0]                sy;
    logic                       hsync;
    logic                       vsync;
    logic                       de;
    logic                       frame;
    logic                       rd_req;
    logic [FB_ADDR_W-1:0]       rd_addr;
    logic                       wr_req;
    logic [FB_ADDR_W-1:0]       wr_addr;
    logic [fb_pkg::COLR_W-1:0]  wr_colr;
    logic                       wr_gnt;
    logic                       ram_en;
    logic                       ram_we;
    logic [FB_ADDR_W-1:0]       ram_addr;
    logic [fb_pkg::COLR_W-1:0]  ram_din;
    logic [fb_pkg::COLR_W-1:0]  ram_dout;

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_timing (
        .clk_pix, .arst_n, .sx, .sy, .hsync, .vsync, .de, .frame
    );

    fb_ram #(.DEPTH(FB_DEPTH), .ADDR_W(FB_ADDR_W)) u_ram (
        .clk_pix, .en(ram_en), .we(ram_we), .addr(ram_addr), .din(ram_din), .dout(ram_dout)
    );

    fb_arbiter #(.ADDR_W(FB_ADDR_W)) u_arb (
        .clk_pix, .arst_n, .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_colr, .wr_gnt,
        .ram_en, .ram_we, .ram_addr, .ram_din
    );

    box_drawer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .ADDR_W(FB_ADDR_W)) u_draw (
        .clk_pix, .arst_n, .draw_start, .draw_colr, .wr_req, .wr_addr, .wr_colr,
        .wr_gnt, .draw_busy
    );

    fb_scanout #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .ADDR_W(FB_ADDR_W)) u_scan (
        .clk_pix, .arst_n, .sx, .sy, .hsync, .vsync, .de, .frame,
        .rd_req, .rd_addr, .rd_data(ram_dout),
        .pix_red, .pix_green, .pix_blue, .pix_hsync, .pix_vsync, .pix_de
    );

endmodule

// ==== tb/tb_fb_top.sv ====
// ==============================
// framebuffer display testbench
// runs the case file, tracks pixels, checks frames
// ==============================
`timescale 1ns/100ps

module tb_fb_top;

    localparam int H_ACTIVE  = 32;
    localparam int H_FP      = 2;
    localparam int H_SYNC    = 3;
    localparam int H_TOTAL   = 40;
    localparam int V_ACTIVE  = 24;
    localparam int V_SYNC    = 2;
    localparam int V_TOTAL   = 28;
    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 12;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int CLK_NS    = 4;

    logic       clk_pix;
    logic       arst_n;
    logic       draw_start;
    logic [3:0] draw_colr;
    logic [7:0] pix_red;
    logic [7:0] pix_green;
    logic [7:0] pix_blue;
    logic       pix_hsync;
    logic       pix_vsync;
    logic       pix_de;
    logic       draw_busy;

    logic [3:0] fb_model [FB_WIDTH * FB_HEIGHT];  // expected framebuffer contents
    logic [7:0] obs_red   [V_ACTIVE][H_ACTIVE];   // last frame seen on the outputs
    logic [7:0] obs_green [V_ACTIVE][H_ACTIVE];
    logic [7:0] obs_blue  [V_ACTIVE][H_ACTIVE];
    logic [7:0] cmd_q [$];
    int         arg_a [$];
    int         arg_b [$];
    int         arg_c [$];
    int         pend_x [$];
    int         pend_y [$];
    int         pend_c [$];
    int         n_cases   = 0;
    int         frame_cnt = 0;
    int         last_cnt  = 0;

    // pixel tracker state
    int px       = 0;
    int py       = -1;
    int pix_cnt  = 0;
    int hs_len   = 0;
    int vs_len   = 0;
    int since_de = 0;
    bit synced      = 1'b0;
    bit line_had_de = 1'b0;
    bit de_q        = 1'b0;
    bit hs_q        = 1'b0;
    bit vs_q        = 1'b0;

    fb_top #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .V_ACTIVE(V_ACTIVE),
        .V_SYNC(V_SYNC), .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)
    ) u_dut (
        .clk_pix, .arst_n, .draw_start, .draw_colr, .pix_red, .pix_green, .pix_blue,
        .pix_hsync, .pix_vsync, .pix_de, .draw_busy
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_NS / 2) clk_pix = ~clk_pix;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // x and y come from pix_de runs and lines restart where pix_vsync falls
    always @(negedge clk_pix) begin
        if (arst_n) begin
            if (pix_de && !de_q) begin
                py          = py + 1;
                px          = 0;
                line_had_de = 1'b1;
            end
            if (pix_de && synced) begin
                if (px >= H_ACTIVE || py >= V_ACTIVE) begin
                    $display("ERROR: visible pixel outside the %0dx%0d screen",
                             H_ACTIVE, V_ACTIVE);
                    abort_run();
                end
                obs_red[py][px]   = pix_red;
                obs_green[py][px] = pix_green;
                obs_blue[py][px]  = pix_blue;
                pix_cnt++;
            end
            if (pix_de) begin
                px++;
            end
            if (pix_hsync) begin
                check_val("pix_de during hsync", 32'(pix_de), 0);
                if (!hs_q && line_had_de) begin
                    check_val("hsync start after de", since_de, H_FP);  // front porch
                end
                line_had_de = 1'b0;
                hs_len++;
            end else if (hs_q) begin
                check_val("hsync width", hs_len, H_SYNC);
                hs_len = 0;
            end
            if (pix_vsync) begin
                check_val("pix_de during vsync", 32'(pix_de), 0);
                vs_len++;
            end else if (vs_q) begin
                check_val("vsync width in cycles", vs_len, V_SYNC * H_TOTAL);
                last_cnt = pix_cnt;
                vs_len   = 0;
                pix_cnt  = 0;
                py       = -1;
                synced   = 1'b1;
                frame_cnt++;
            end
            since_de = pix_de ? 0 : since_de + 1;
            de_q     = pix_de;
            hs_q     = pix_hsync;
            vs_q     = pix_vsync;
        end
    end

    function automatic logic [7:0] model_pixel(input int x, input int y);
        logic [3:0] colr;
        colr = '0;
        if (x < FB_WIDTH && y < FB_HEIGHT) begin
            colr = fb_model[y * FB_WIDTH + x];
        end
        return {colr, colr};  // nibble fills both halves of a channel
    endfunction

    task automatic paint_border(input logic [3:0] colr);
        for (int x = 0; x < FB_WIDTH; x++) begin
            fb_model[x] = colr;
            fb_model[(FB_HEIGHT - 1) * FB_WIDTH + x] = colr;
        end
        for (int y = 0; y < FB_HEIGHT; y++) begin
            fb_model[y * FB_WIDTH] = colr;
            fb_model[y * FB_WIDTH + FB_WIDTH - 1] = colr;
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        wait (frame_cnt >= target);
    endtask

    task automatic pulse_start(input logic [3:0] colr);
        @(posedge clk_pix);
        #1;
        draw_start = 1'b1;
        draw_colr  = colr;
        @(posedge clk_pix);
        #1;
        draw_start = 1'b0;
    endtask

    task automatic draw_box(input logic [3:0] colr, input bit overlap,
                            input logic [3:0] colr2);
        int idle;
        int n;
        idle = int'($urandom % 32);
        n    = 0;
        wait_frames(1);
        repeat (idle) @(posedge clk_pix);
        pulse_start(colr);
        check_val("draw_busy after draw_start", 32'(draw_busy), 1);
        if (overlap) begin
            @(posedge clk_pix);
            #1;
            check_val("draw_busy before second start", 32'(draw_busy), 1);
            pulse_start(colr2);  // lands mid draw and must be ignored
        end
        paint_border(colr);
        while (draw_busy) begin
            @(posedge clk_pix);
            #1;
            n++;
            if (n > 2 * FRAME_CYC) begin
                $display("ERROR: draw_busy still high two frames after draw_start");
                abort_run();
            end
        end
        wait_frames(2);
    endtask

    task automatic check_frame();
        int         x;
        int         y;
        int         c;
        logic [7:0] exp;
        wait_frames(2);  // the second vsync fall closes a whole frame
        check_val("visible pixels in frame", last_cnt, H_ACTIVE * V_ACTIVE);
        for (y = 0; y < V_ACTIVE; y++) begin
            for (x = 0; x < H_ACTIVE; x++) begin
                exp = model_pixel(x, y);
                check_val($sformatf("pix_red at %0d,%0d", x, y), 32'(obs_red[y][x]), 32'(exp));
                check_val($sformatf("pix_green at %0d,%0d", x, y), 32'(obs_green[y][x]),
                          32'(exp));
                check_val($sformatf("pix_blue at %0d,%0d", x, y), 32'(obs_blue[y][x]), 32'(exp));
            end
        end
        while (pend_x.size() > 0) begin
            x   = pend_x.pop_front();
            y   = pend_y.pop_front();
            c   = pend_c.pop_front();
            exp = {c[3:0], c[3:0]};
            if (x < 0 || y < 0 || x >= H_ACTIVE || y >= V_ACTIVE) begin
                $display("ERROR: case pixel %0d,%0d is not on the screen", x, y);
                abort_run();
            end
            check_val($sformatf("case pix_red at %0d,%0d", x, y), 32'(obs_red[y][x]), 32'(exp));
            check_val($sformatf("case pix_green at %0d,%0d", x, y), 32'(obs_green[y][x]),
                      32'(exp));
            check_val($sformatf("case pix_blue at %0d,%0d", x, y), 32'(obs_blue[y][x]),
                      32'(exp));
        end
    endtask

    task automatic read_cases();
        int               fd;
        int               code;
        int               a;
        int               b;
        int               c;
        logic [7:0]       tok;
        logic [8*128-1:0] rest;
        fd = $fopen("tb/fb_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tb/fb_cases.txt");
            abort_run();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            a = 0;
            b = 0;
            c = 0;
            if (tok == "#") begin
                code = $fgets(rest, fd);  // rest of a comment line
            end else begin
                case (tok)
                    "D":     code = $fscanf(fd, "%h", a) - 1;
                    "B":     code = $fscanf(fd, "%h %h", a, b) - 2;
                    "P":     code = $fscanf(fd, "%d %d %h", a, b, c) - 3;
                    "F":     code = 0;
                    default: code = -1;
                endcase
                if (code != 0) begin
                    $display("ERROR: malformed case line after %0d cases", cmd_q.size());
                    abort_run();
                end
                cmd_q.push_back(tok);
                arg_a.push_back(a);
                arg_b.push_back(b);
                arg_c.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        void'($urandom(32'h3063_c698));
        arst_n     = 1'b0;
        draw_start = 1'b0;
        draw_colr  = '0;
        foreach (fb_model[i]) begin
            fb_model[i] = '0;
        end
        read_cases();
        if (cmd_q.size() == 0) begin
            $display("ERROR: the case file holds no cases");
            abort_run();
        end
        n_cases = cmd_q.size();
        repeat (8) @(posedge clk_pix);
        check_val("draw_busy in reset", 32'(draw_busy), 0);
        check_val("pix_de in reset", 32'(pix_de), 0);
        #1 arst_n = 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            case (cmd_q[i])
                "D": draw_box(4'(arg_a[i]), 1'b0, 4'h0);
                "B": draw_box(4'(arg_a[i]), 1'b1, 4'(arg_b[i]));
                "P": begin
                    pend_x.push_back(arg_a[i]);
                    pend_y.push_back(arg_b[i]);
                    pend_c.push_back(arg_c[i]);
                end
                default: check_frame();
            endcase
        end
        $display("Testbench passed");
        $finish;
    end

    // four frames of budget per case line
    initial begin
        wait (n_cases > 0);
        #(longint'(n_cases) * 4 * FRAME_CYC * CLK_NS);
        $display("ERROR: run timed out after %0d case lines", n_cases);
        abort_run();
    end

endmodule

// ==== tb/fb_cases.txt ====
# D colour | B colour colour (second start while busy) | F (check one frame)
# P x y colour (expected pixel in the next F, x y decimal, colour hex)
P 0 0 0
P 15 11 0
F
D A
P 0 0 A
P 15 11 A
P 7 0 A
P 0 6 A
P 5 5 0
P 16 0 0
P 0 12 0
F
D 3
P 15 5 3
P 5 5 0
F
B 5 C
P 9 11 5
P 6 6 0
F

// ==== sim.f ====
verilog/fb_pkg.sv
verilog/display_timing.sv
verilog/fb_ram.sv
verilog/fb_arbiter.sv
verilog/box_drawer.sv
verilog/fb_scanout.sv
verilog/fb_top.sv
tb/tb_fb_top.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_fb_top
FILELIST = sim.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
